//--- Makefile
TOP = rv_backend_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rv_backend.f -o sim
	./obj_dir/sim

lint:
	verilator --lint-only --timing --top-module rv_backend -f rv_backend.f

clean:
	rm -rf obj_dir

//--- bench/rv_backend_patterns.txt
// Memory words 0 to 3, then the number of operations (hex).
// mem_op rd rd_we result/address store_data csr_swap csr_addr csr_value
// redirect_kind redirect_target break expected_rd_value
8421f07e 80ff7f80 12345678 deadbeef
1e
0 01 1 11111111 00000000 0 000 00000000 0 00000000 0 11111111
0 02 1 22222222 00000000 0 000 00000000 0 00000000 0 22222222
0 00 1 abcdef01 00000000 0 000 00000000 0 00000000 0 00000000
1 03 1 00000000 00000000 0 000 00000000 0 00000000 0 0000007e
1 03 1 00000001 00000000 0 000 00000000 0 00000000 0 fffffff0
1 03 1 00000002 00000000 0 000 00000000 0 00000000 0 00000021
1 03 1 00000003 00000000 0 000 00000000 0 00000000 0 ffffff84
4 04 1 00000004 00000000 0 000 00000000 0 00000000 0 00000080
4 04 1 00000005 00000000 0 000 00000000 0 00000000 0 0000007f
4 04 1 00000006 00000000 0 000 00000000 0 00000000 0 000000ff
4 04 1 00000007 00000000 0 000 00000000 0 00000000 0 00000080
2 03 1 00000000 00000000 0 000 00000000 0 00000000 0 fffff07e
2 03 1 00000002 00000000 0 000 00000000 0 00000000 0 ffff8421
5 04 1 00000004 00000000 0 000 00000000 0 00000000 0 00007f80
5 04 1 00000006 00000000 0 000 00000000 0 00000000 0 000080ff
3 05 1 00000008 00000000 0 000 00000000 0 00000000 0 12345678
6 06 1 0000000d 000000aa 0 000 00000000 0 00000000 0 00000000
7 06 1 0000000e 00005566 0 000 00000000 0 00000000 0 00000000
3 05 1 0000000c 00000000 0 000 00000000 0 00000000 0 5566aaef
8 06 1 00000008 cafef00d 0 000 00000000 0 00000000 0 00000000
3 05 1 00000008 00000000 0 000 00000000 0 00000000 0 cafef00d
0 07 1 00000000 00000000 1 340 0badc0de 0 00000000 0 00000000
0 08 1 00000000 00000000 1 340 12121212 0 00000000 0 0badc0de
0 09 1 00000000 00000000 1 7c0 ffffffff 0 00000000 0 00000000
0 09 1 00000000 00000000 1 7c0 00000001 0 00000000 0 00000000
0 0a 1 00000044 00000000 0 000 00000000 1 00001000 0 00000044
0 00 0 00000000 00000000 0 000 00000000 2 00002000 0 00000000
0 00 0 00000000 00000000 0 000 00000000 3 00003000 0 00000000
0 0b 1 00000055 00000000 0 000 00000000 0 00000000 1 00000055
0 0c 1 00000066 00000000 0 000 00000000 0 00000000 0 00000066

//--- bench/rv_backend_tb.sv
`timescale 1ns/1ps
`include "rv_backend_params.svh"

module rv_backend_tb;

    // Words 0 to 3 preload the memory, word 4 counts the operations,
    // and each operation then takes 12 words.
    localparam int PRELOAD_WORDS = 4;
    localparam int OP_WORDS      = 12;
    localparam int CYCLES_PER_OP = 40;

    logic                        clock;
    logic                        reset;
    logic                        ex_valid_i;
    logic                        ex_ready_o;
    rv_backend_pkg::mem_op_e     ex_mem_op_i;
    logic [`RV_REG_ADDR_W-1:0]   ex_rd_i;
    logic                        ex_rd_we_i;
    logic [`RV_XLEN-1:0]         ex_result_i;
    logic [`RV_XLEN-1:0]         ex_store_data_i;
    logic                        ex_csr_swap_i;
    logic [`RV_CSR_ADDR_W-1:0]   ex_csr_addr_i;
    logic [`RV_XLEN-1:0]         ex_csr_wdata_i;
    rv_backend_pkg::redirect_e   ex_redirect_i;
    logic [`RV_XLEN-1:0]         ex_target_i;
    logic                        ex_break_i;
    logic                        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`RV_XLEN-3:0]         wb_adr;
    logic [`RV_SEL_W-1:0]        wb_sel;
    logic [`RV_XLEN-1:0]         wb_wdata, wb_rdata;
    logic [`RV_REG_ADDR_W-1:0]   rs1_addr_i, rs2_addr_i;
    logic [`RV_XLEN-1:0]         rs1_data_o, rs2_data_o;
    logic                        retire_o, redirect_valid_o, halt_o;
    rv_backend_pkg::redirect_e   redirect_kind_o;
    logic [`RV_XLEN-1:0]         redirect_target_o;

    logic [31:0] pattern [0:511];
    int          op_count;
    int          retired;
    int          checked;

    rv_backend i_dut (
        .clock(clock), .reset(reset),
        .ex_valid_i(ex_valid_i), .ex_ready_o(ex_ready_o), .ex_mem_op_i(ex_mem_op_i),
        .ex_rd_i(ex_rd_i), .ex_rd_we_i(ex_rd_we_i), .ex_result_i(ex_result_i),
        .ex_store_data_i(ex_store_data_i), .ex_csr_swap_i(ex_csr_swap_i),
        .ex_csr_addr_i(ex_csr_addr_i), .ex_csr_wdata_i(ex_csr_wdata_i),
        .ex_redirect_i(ex_redirect_i), .ex_target_i(ex_target_i), .ex_break_i(ex_break_i),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_sel_o(wb_sel), .wb_dat_o(wb_wdata), .wb_dat_i(wb_rdata), .wb_ack_i(wb_ack),
        .rs1_addr_i(rs1_addr_i), .rs2_addr_i(rs2_addr_i),
        .rs1_data_o(rs1_data_o), .rs2_data_o(rs2_data_o),
        .retire_o(retire_o), .redirect_valid_o(redirect_valid_o),
        .redirect_kind_o(redirect_kind_o), .redirect_target_o(redirect_target_o),
        .halt_o(halt_o)
    );

    wb_data_memory i_mem (
        .clock(clock), .reset(reset), .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
        .adr_i(wb_adr), .sel_i(wb_sel), .dat_i(wb_wdata), .dat_o(wb_rdata), .ack_o(wb_ack)
    );

    always #2 clock = ~clock;

    function automatic int op_base(input int index);
        return PRELOAD_WORDS + 1 + OP_WORDS * index;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual,
                     expected);
            $display("test failed");
            $fatal(1, "check failed");
        end
    endtask

    task automatic drive_op(input int base);
        ex_valid_i      = 1'b1;
        ex_mem_op_i     = rv_backend_pkg::mem_op_e'(pattern[base][3:0]);
        ex_rd_i         = pattern[base+1][`RV_REG_ADDR_W-1:0];
        ex_rd_we_i      = pattern[base+2][0];
        ex_result_i     = pattern[base+3];
        ex_store_data_i = pattern[base+4];
        ex_csr_swap_i   = pattern[base+5][0];
        ex_csr_addr_i   = pattern[base+6][`RV_CSR_ADDR_W-1:0];
        ex_csr_wdata_i  = pattern[base+7];
        ex_redirect_i   = rv_backend_pkg::redirect_e'(pattern[base+8][1:0]);
        ex_target_i     = pattern[base+9];
        ex_break_i      = pattern[base+10][0];
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        retired         = 0;
        checked         = 0;
        ex_valid_i      = 1'b0;
        ex_mem_op_i     = rv_backend_pkg::MEM_NONE;
        ex_rd_i         = '0;
        ex_rd_we_i      = 1'b0;
        ex_result_i     = '0;
        ex_store_data_i = '0;
        ex_csr_swap_i   = 1'b0;
        ex_csr_addr_i   = '0;
        ex_csr_wdata_i  = '0;
        ex_redirect_i   = rv_backend_pkg::REDIR_NONE;
        ex_target_i     = '0;
        ex_break_i      = 1'b0;
        rs1_addr_i      = '0;
        rs2_addr_i      = '0;
        $readmemh("bench/rv_backend_patterns.txt", pattern);
        op_count = pattern[PRELOAD_WORDS];
        for (int w = 0; w < PRELOAD_WORDS; w++) begin
            i_mem.mem[w] = pattern[w];
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value(ex_ready_o, 1'b1, "ex_ready_o after reset");
        check_value(wb_cyc, 1'b0, "wb_cyc_o after reset");
        check_value(wb_stb, 1'b0, "wb_stb_o after reset");
        check_value(retire_o, 1'b0, "retire_o after reset");
        check_value(halt_o, 1'b0, "halt_o after reset");
        for (int i = 0; i < op_count; i++) begin
            drive_op(op_base(i));
            while (!ex_ready_o) begin
                @(negedge clock);
            end
            @(negedge clock);
            // A memory access holds off the next operation until its ack.
            if (ex_mem_op_i != rv_backend_pkg::MEM_NONE) begin
                check_value(ex_ready_o, 1'b0, "ex_ready_o during memory access");
            end
        end
        ex_valid_i = 1'b0;
        wait (checked == op_count);
        $display("test passed");
        $finish;
    end

    // ----------------------------------------
    // Retirement checks
    // ----------------------------------------
    initial begin : retire_checker
        int base;
        bit pending;
        bit halt_seen;
        pending   = 1'b0;
        halt_seen = 1'b0;
        @(negedge reset);
        forever begin
            @(negedge clock);
            // The register was written on the edge after retirement.
            if (pending) begin
                check_value(rs1_data_o, pattern[base+11], "register read on rs1");
                check_value(rs2_data_o, pattern[base+11], "register read on rs2");
                pending = 1'b0;
                checked++;
            end
            if (retire_o) begin
                if (retired >= op_count) begin
                    $display("An operation retired that was never issued");
                    $display("test failed");
                    $fatal(1, "extra retirement");
                end
                base = op_base(retired);
                check_value(redirect_valid_o, pattern[base+8] != 0, "redirect_valid_o");
                if (pattern[base+8] != 0) begin
                    check_value(redirect_kind_o, pattern[base+8], "redirect_kind_o");
                    check_value(redirect_target_o, pattern[base+9], "redirect_target_o");
                end
                check_value(halt_o, halt_seen || pattern[base+10][0], "halt_o at retire");
                halt_seen  = halt_seen || pattern[base+10][0];
                rs1_addr_i = pattern[base+1][`RV_REG_ADDR_W-1:0];
                rs2_addr_i = pattern[base+1][`RV_REG_ADDR_W-1:0];
                pending    = 1'b1;
                retired++;
            end else begin
                check_value(redirect_valid_o, 1'b0, "redirect_valid_o between retirements");
                check_value(halt_o, halt_seen, "halt_o between retirements");
            end
        end
    end

    initial begin : watchdog
        @(negedge reset);
        repeat (op_count * CYCLES_PER_OP) @(posedge clock);
        $display("Timeout: the operations did not all retire within %0d cycles",
                 op_count * CYCLES_PER_OP);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- bench/wb_data_memory.sv
`timescale 1ns/1ps

// Wishbone classic slave with four words of storage.
// Each request waits a random 0 to 3 idle cycles before its acknowledge.
module wb_data_memory (
    input  logic        clock,
    input  logic        reset,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [29:0] adr_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem [0:3];
    integer      seed = 32'h8e06d3ec;
    logic        busy;
    logic [1:0]  idle_left;

    always @(posedge clock) begin
        ack_o <= 1'b0;
        if (reset) begin
            busy <= 1'b0;
        end else if (cyc_i && stb_i && !ack_o) begin
            if (!busy) begin
                busy      <= 1'b1;
                idle_left <= 2'($random(seed));
            end else if (idle_left != 2'd0) begin
                idle_left <= idle_left - 2'd1;
            end else begin
                // Only the selected byte lanes are written.
                busy  <= 1'b0;
                ack_o <= 1'b1;
                dat_o <= mem[adr_i[1:0]];
                if (we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            mem[adr_i[1:0]][8*b +: 8] <= dat_i[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- rv_backend.f
+incdir+verilog
verilog/rv_backend_pkg.sv
verilog/lsu_wbu_if.sv
verilog/lsu.sv
verilog/wbu.sv
verilog/reg_file.sv
verilog/csr_file.sv
verilog/rv_backend.sv
bench/wb_data_memory.sv
bench/rv_backend_tb.sv

//--- verilog/csr_file.sv
`timescale 1ns/1ps
`include "rv_backend_params.svh"

module csr_file (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`RV_CSR_ADDR_W-1:0]   addr_i,
    output logic [`RV_XLEN-1:0]         rdata_o,
    input  logic                        we_i,
    input  logic [`RV_XLEN-1:0]         wdata_i
);

    logic [`RV_XLEN-1:0] mstatus;
    logic [`RV_XLEN-1:0] mtvec;
    logic [`RV_XLEN-1:0] mscratch;
    logic [`RV_XLEN-1:0] mepc;
    logic [`RV_XLEN-1:0] mcause;

    // ----------------------------------------
    // Read decode
    // ----------------------------------------
    always_comb begin
        case (addr_i)
            `RV_CSR_MSTATUS:  rdata_o = mstatus;
            `RV_CSR_MTVEC:    rdata_o = mtvec;
            `RV_CSR_MSCRATCH: rdata_o = mscratch;
            `RV_CSR_MEPC:     rdata_o = mepc;
            `RV_CSR_MCAUSE:   rdata_o = mcause;
            default:          rdata_o = '0;
        endcase
    end

    // Writes to an unknown address are dropped.
    always_ff @(posedge clock) begin
        if (reset) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (we_i) begin
            case (addr_i)
                `RV_CSR_MSTATUS:  mstatus  <= wdata_i;
                `RV_CSR_MTVEC:    mtvec    <= wdata_i;
                `RV_CSR_MSCRATCH: mscratch <= wdata_i;
                `RV_CSR_MEPC:     mepc     <= wdata_i;
                `RV_CSR_MCAUSE:   mcause   <= wdata_i;
                default:          ;
            endcase
        end
    end

endmodule

//--- verilog/lsu.sv
`timescale 1ns/1ps
`include "rv_backend_params.svh"

module lsu (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        ex_valid_i,
    output logic                        ex_ready_o,
    input  rv_backend_pkg::mem_op_e     ex_mem_op_i,
    input  logic [`RV_REG_ADDR_W-1:0]   ex_rd_i,
    input  logic                        ex_rd_we_i,
    input  logic [`RV_XLEN-1:0]         ex_result_i,
    input  logic [`RV_XLEN-1:0]         ex_store_data_i,
    input  logic                        ex_csr_swap_i,
    input  logic [`RV_CSR_ADDR_W-1:0]   ex_csr_addr_i,
    input  logic [`RV_XLEN-1:0]         ex_csr_wdata_i,
    input  rv_backend_pkg::redirect_e   ex_redirect_i,
    input  logic [`RV_XLEN-1:0]         ex_target_i,
    input  logic                        ex_break_i,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [`RV_XLEN-3:0]         wb_adr_o,
    output logic [`RV_SEL_W-1:0]        wb_sel_o,
    output logic [`RV_XLEN-1:0]         wb_dat_o,
    input  logic [`RV_XLEN-1:0]         wb_dat_i,
    input  logic                        wb_ack_i,
    lsu_wbu_if.lsu                      out
);

    typedef enum logic {ST_IDLE, ST_WAIT} state_e;

    state_e                        state_q;
    rv_backend_pkg::stage_result_t in_result;
    rv_backend_pkg::stage_result_t pending_q;
    rv_backend_pkg::stage_result_t ack_result;
    rv_backend_pkg::mem_op_e       op_q;
    logic [1:0]                    off_q;
    logic                          accept;
    logic                          is_mem_in;
    logic                          is_store_in;
    logic [`RV_SEL_W-1:0]          sel_in;
    logic [`RV_XLEN-1:0]           dat_in;
    logic [7:0]                    lane_byte;
    logic [15:0]                   lane_half;
    logic [`RV_XLEN-1:0]           load_data;

    assign ex_ready_o  = (state_q == ST_IDLE);
    assign accept      = ex_valid_i && ex_ready_o;
    assign is_mem_in   = (ex_mem_op_i != rv_backend_pkg::MEM_NONE);
    assign is_store_in = (ex_mem_op_i == rv_backend_pkg::MEM_SB) ||
                         (ex_mem_op_i == rv_backend_pkg::MEM_SH) ||
                         (ex_mem_op_i == rv_backend_pkg::MEM_SW);

    // Stores never write a register.
    always_comb begin
        in_result.rd_we     = ex_rd_we_i && !is_store_in;
        in_result.rd        = ex_rd_i;
        in_result.result    = ex_result_i;
        in_result.csr_swap  = ex_csr_swap_i;
        in_result.csr_addr  = ex_csr_addr_i;
        in_result.csr_wdata = ex_csr_wdata_i;
        in_result.redirect  = ex_redirect_i;
        in_result.target    = ex_target_i;
        in_result.brk       = ex_break_i;
    end

    // ----------------------------------------
    // Byte lanes for the outgoing request
    // ----------------------------------------
    always_comb begin
        case (ex_mem_op_i)
            rv_backend_pkg::MEM_LB, rv_backend_pkg::MEM_LBU, rv_backend_pkg::MEM_SB: begin
                sel_in = 4'b0001 << ex_result_i[1:0];
                dat_in = {4{ex_store_data_i[7:0]}};
            end
            rv_backend_pkg::MEM_LH, rv_backend_pkg::MEM_LHU, rv_backend_pkg::MEM_SH: begin
                sel_in = 4'b0011 << {ex_result_i[1], 1'b0};
                dat_in = {2{ex_store_data_i[15:0]}};
            end
            default: begin
                sel_in = 4'b1111;
                dat_in = ex_store_data_i;
            end
        endcase
    end

    // Load alignment and extension, taken from the bus on the ack edge.
    always_comb begin
        lane_byte = wb_dat_i[8*off_q +: 8];
        lane_half = wb_dat_i[16*off_q[1] +: 16];
        ack_result = pending_q;
        case (op_q)
            rv_backend_pkg::MEM_LB:  load_data = {{(`RV_XLEN-8){lane_byte[7]}}, lane_byte};
            rv_backend_pkg::MEM_LBU: load_data = {{(`RV_XLEN-8){1'b0}}, lane_byte};
            rv_backend_pkg::MEM_LH:  load_data = {{(`RV_XLEN-16){lane_half[15]}}, lane_half};
            rv_backend_pkg::MEM_LHU: load_data = {{(`RV_XLEN-16){1'b0}}, lane_half};
            default:                 load_data = wb_dat_i;
        endcase
        if (!wb_we_o) begin
            ack_result.result = load_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            out.valid <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept && is_mem_in) begin
                        state_q  <= ST_WAIT;
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                    end else if (accept) begin
                        out.valid <= 1'b1;
                    end
                end
                default: begin
                    if (wb_ack_i) begin
                        state_q   <= ST_IDLE;
                        wb_cyc_o  <= 1'b0;
                        wb_stb_o  <= 1'b0;
                        out.valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pending_q <= in_result;
            op_q      <= ex_mem_op_i;
            off_q     <= ex_result_i[1:0];
            wb_we_o   <= is_store_in;
            wb_adr_o  <= ex_result_i[`RV_XLEN-1:2];
            wb_sel_o  <= sel_in;
            wb_dat_o  <= dat_in;
        end
        if (accept && !is_mem_in) begin
            out.result <= in_result;
        end else if (state_q == ST_WAIT && wb_ack_i) begin
            out.result <= ack_result;
        end
    end

    stb_needs_cyc: assert property (@(posedge clock) disable iff (reset)
        wb_stb_o |-> wb_cyc_o);

    // A request is held unchanged until the slave acknowledges it.
    stb_held_stable: assert property (@(posedge clock) disable iff (reset)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_sel_o)
            && $stable(wb_we_o) && $stable(wb_dat_o));

endmodule

//--- verilog/lsu_wbu_if.sv
`timescale 1ns/1ps

// One retiring operation per valid cycle.
// Writeback never stalls, so there is no ready.
interface lsu_wbu_if;

    logic                         valid;
    rv_backend_pkg::stage_result_t result;

    modport lsu (
        output valid,
        output result
    );

    modport wbu (
        input valid,
        input result
    );

endinterface

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "rv_backend_params.svh"

module reg_file (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        we_i,
    input  logic [`RV_REG_ADDR_W-1:0]   waddr_i,
    input  logic [`RV_XLEN-1:0]         wdata_i,
    input  logic [`RV_REG_ADDR_W-1:0]   raddr1_i,
    input  logic [`RV_REG_ADDR_W-1:0]   raddr2_i,
    output logic [`RV_XLEN-1:0]         rdata1_o,
    output logic [`RV_XLEN-1:0]         rdata2_o
);

    // x0 has no storage.
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads are combinational, so a written value shows after the write edge.
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- verilog/rv_backend.sv
`timescale 1ns/1ps
`include "rv_backend_params.svh"

module rv_backend (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        ex_valid_i,
    output logic                        ex_ready_o,
    input  rv_backend_pkg::mem_op_e     ex_mem_op_i,
    input  logic [`RV_REG_ADDR_W-1:0]   ex_rd_i,
    input  logic                        ex_rd_we_i,
    input  logic [`RV_XLEN-1:0]         ex_result_i,
    input  logic [`RV_XLEN-1:0]         ex_store_data_i,
    input  logic                        ex_csr_swap_i,
    input  logic [`RV_CSR_ADDR_W-1:0]   ex_csr_addr_i,
    input  logic [`RV_XLEN-1:0]         ex_csr_wdata_i,
    input  rv_backend_pkg::redirect_e   ex_redirect_i,
    input  logic [`RV_XLEN-1:0]         ex_target_i,
    input  logic                        ex_break_i,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [`RV_XLEN-3:0]         wb_adr_o,
    output logic [`RV_SEL_W-1:0]        wb_sel_o,
    output logic [`RV_XLEN-1:0]         wb_dat_o,
    input  logic [`RV_XLEN-1:0]         wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rs1_addr_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rs2_addr_i,
    output logic [`RV_XLEN-1:0]         rs1_data_o,
    output logic [`RV_XLEN-1:0]         rs2_data_o,
    output logic                        retire_o,
    output logic                        redirect_valid_o,
    output rv_backend_pkg::redirect_e   redirect_kind_o,
    output logic [`RV_XLEN-1:0]         redirect_target_o,
    output logic                        halt_o
);

    logic                        rf_we;
    logic [`RV_REG_ADDR_W-1:0]   rf_rd;
    logic [`RV_XLEN-1:0]         rf_wdata;
    logic [`RV_CSR_ADDR_W-1:0]   csr_addr;
    logic                        csr_we;
    logic [`RV_XLEN-1:0]         csr_wdata;
    logic [`RV_XLEN-1:0]         csr_rdata;

    lsu_wbu_if lsu_wbu ();

    // ----------------------------------------
    // Pipeline stages
    // ----------------------------------------
    lsu i_lsu (
        .clock           (clock),
        .reset           (reset),
        .ex_valid_i      (ex_valid_i),
        .ex_ready_o      (ex_ready_o),
        .ex_mem_op_i     (ex_mem_op_i),
        .ex_rd_i         (ex_rd_i),
        .ex_rd_we_i      (ex_rd_we_i),
        .ex_result_i     (ex_result_i),
        .ex_store_data_i (ex_store_data_i),
        .ex_csr_swap_i   (ex_csr_swap_i),
        .ex_csr_addr_i   (ex_csr_addr_i),
        .ex_csr_wdata_i  (ex_csr_wdata_i),
        .ex_redirect_i   (ex_redirect_i),
        .ex_target_i     (ex_target_i),
        .ex_break_i      (ex_break_i),
        .wb_cyc_o        (wb_cyc_o),
        .wb_stb_o        (wb_stb_o),
        .wb_we_o         (wb_we_o),
        .wb_adr_o        (wb_adr_o),
        .wb_sel_o        (wb_sel_o),
        .wb_dat_o        (wb_dat_o),
        .wb_dat_i        (wb_dat_i),
        .wb_ack_i        (wb_ack_i),
        .out             (lsu_wbu)
    );

    wbu i_wbu (
        .clock             (clock),
        .reset             (reset),
        .in                (lsu_wbu),
        .rf_we_o           (rf_we),
        .rf_rd_o           (rf_rd),
        .rf_wdata_o        (rf_wdata),
        .csr_addr_o        (csr_addr),
        .csr_we_o          (csr_we),
        .csr_wdata_o       (csr_wdata),
        .csr_rdata_i       (csr_rdata),
        .retire_o          (retire_o),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_kind_o   (redirect_kind_o),
        .redirect_target_o (redirect_target_o),
        .halt_o            (halt_o)
    );

    // ----------------------------------------
    // Architectural state
    // ----------------------------------------
    reg_file i_reg_file (
        .clock    (clock),
        .reset    (reset),
        .we_i     (rf_we),
        .waddr_i  (rf_rd),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

    csr_file i_csr_file (
        .clock   (clock),
        .reset   (reset),
        .addr_i  (csr_addr),
        .rdata_o (csr_rdata),
        .we_i    (csr_we),
        .wdata_i (csr_wdata)
    );

endmodule

//--- verilog/rv_backend_params.svh
`ifndef RV_BACKEND_PARAMS_SVH
`define RV_BACKEND_PARAMS_SVH

// Data path and address widths.
`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_CSR_ADDR_W   12

// Byte lanes on the data bus.
`define RV_SEL_W        (`RV_XLEN / 8)

// ----------------------------------------
// Machine-mode CSR addresses
// ----------------------------------------
`define RV_CSR_MSTATUS  12'h300
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

`endif

//--- verilog/rv_backend_pkg.sv
`include "rv_backend_params.svh"

package rv_backend_pkg;

    // Memory action of one operation.
    // The encoding is fixed because the pattern file uses it directly.
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // Control change published at retirement.
    typedef enum logic [1:0] {
        REDIR_NONE      = 2'd0,
        REDIR_JUMP      = 2'd1,
        REDIR_EXCEPTION = 2'd2,
        REDIR_XRET      = 2'd3
    } redirect_e;

    // ----------------------------------------
    // Result handed from memory stage to writeback
    // ----------------------------------------
    typedef struct packed {
        logic                      rd_we;
        logic [`RV_REG_ADDR_W-1:0] rd;
        // ALU result, or the extended load data for loads.
        logic [`RV_XLEN-1:0]       result;
        logic                      csr_swap;
        logic [`RV_CSR_ADDR_W-1:0] csr_addr;
        logic [`RV_XLEN-1:0]       csr_wdata;
        redirect_e                 redirect;
        logic [`RV_XLEN-1:0]       target;
        logic                      brk;
    } stage_result_t;

endpackage

//--- verilog/wbu.sv
`timescale 1ns/1ps
`include "rv_backend_params.svh"

module wbu (
    input  logic                        clock,
    input  logic                        reset,
    lsu_wbu_if.wbu                      in,
    output logic                        rf_we_o,
    output logic [`RV_REG_ADDR_W-1:0]   rf_rd_o,
    output logic [`RV_XLEN-1:0]         rf_wdata_o,
    output logic [`RV_CSR_ADDR_W-1:0]   csr_addr_o,
    output logic                        csr_we_o,
    output logic [`RV_XLEN-1:0]         csr_wdata_o,
    input  logic [`RV_XLEN-1:0]         csr_rdata_i,
    output logic                        retire_o,
    output logic                        redirect_valid_o,
    output rv_backend_pkg::redirect_e   redirect_kind_o,
    output logic [`RV_XLEN-1:0]         redirect_target_o,
    output logic                        halt_o
);

    rv_backend_pkg::stage_result_t held_q;
    logic                          retire_q;
    logic                          halt_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            retire_q <= 1'b0;
            halt_q   <= 1'b0;
        end else begin
            retire_q <= in.valid;
            if (retire_q && held_q.brk) begin
                halt_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in.valid) begin
            held_q <= in.result;
        end
    end

    // ----------------------------------------
    // Commit
    // ----------------------------------------
    assign retire_o = retire_q;
    assign rf_we_o  = retire_q && held_q.rd_we;
    assign rf_rd_o  = held_q.rd;

    // A swap hands the old CSR value to rd in the same edge the CSR takes the new one.
    assign rf_wdata_o  = held_q.csr_swap ? csr_rdata_i : held_q.result;
    assign csr_addr_o  = held_q.csr_addr;
    assign csr_we_o    = retire_q && held_q.csr_swap;
    assign csr_wdata_o = held_q.csr_wdata;

    assign redirect_valid_o  = retire_q && (held_q.redirect != rv_backend_pkg::REDIR_NONE);
    assign redirect_kind_o   = held_q.redirect;
    assign redirect_target_o = held_q.target;

    // Halt shows in the retiring cycle and then sticks.
    assign halt_o = halt_q || (retire_q && held_q.brk);

    // A write commits only for a result that arrived one cycle earlier and asked for it.
    we_only_on_retire: assert property (@(posedge clock) disable iff (reset)
        (rf_we_o || csr_we_o) |-> retire_o
            && $past(in.valid && (in.result.rd_we || in.result.csr_swap)));

endmodule
